//--- build.f
+incdir+include
rtl/init_table_pkg.sv
rtl/i2c_cmd_pkg.sv
rtl/init_cmd_if.sv
rtl/init_rom.sv
rtl/init_sequencer.sv
rtl/i2c_cmd_out.sv
rtl/i2c_init.sv
verification/tb_clk_gen.sv
verification/i2c_init_chk.sv
verification/i2c_init_tb.sv

//--- Bender.yml
package:
  name: i2c_init

export_include_dirs:
  - include

sources:
  - rtl/init_table_pkg.sv
  - rtl/i2c_cmd_pkg.sv
  - rtl/init_cmd_if.sv
  - rtl/init_rom.sv
  - rtl/init_sequencer.sv
  - rtl/i2c_cmd_out.sv
  - rtl/i2c_init.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/i2c_init_chk.sv
      - verification/i2c_init_tb.sv

//--- verification/i2c_init_tb.sv
// i2c_init_tb directed tests, expected command model, checks and watchdog
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

module i2c_init_tb;
    import init_table_pkg::*;
    import i2c_cmd_pkg::*;

    localparam int num_tests = 4;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   busy;
    logic [`I2C_ADDR_W-1:0] cmd_address;
    logic                   cmd_start;
    logic                   cmd_write;
    logic                   cmd_stop;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [`I2C_DATA_W-1:0] data_tdata;
    logic                   data_tvalid;
    logic                   data_tready;
    logic                   rand_ready;
    // cmd words packed as start, write, stop, address
    logic [`I2C_ADDR_W+2:0] cmd_exp[$];
    logic [`I2C_ADDR_W+2:0] cmd_act[$];
    logic [`I2C_DATA_W-1:0] data_exp[$];
    logic [`I2C_DATA_W-1:0] data_act[$];
    logic                   model_start;
    logic [`I2C_ADDR_W-1:0] model_addr;
    // table data block and address block, entry encoding
    init_entry_t data_blk[6] = '{9'h100, 9'h104, 9'h111, 9'h122, 9'h133, 9'h144};
    init_entry_t addr_blk[4] = '{{2'b01, 7'h50}, {2'b01, 7'h51}, {2'b01, 7'h52}, {2'b01, 7'h53}};

    tb_clk_gen #(.period(20.0), .rst_cycles(4)) clk_gen0 (.clk(clk), .rst(rst));

    i2c_init dut0 (.*);

    bind i2c_init i2c_init_chk chk0 (.*);

    // address only compared on write words
    function automatic logic [`I2C_ADDR_W+2:0] pack_cmd(logic s, logic w, logic p,
                                                       logic [`I2C_ADDR_W-1:0] a);
        return {s, w, p, w ? a : '0};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, act, exp);
            $display("Test FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // one request as the output stage sees it
    task automatic model_req(input cmd_kind_e kind, input logic [7:0] value);
        case (kind)
            kind_set_addr: begin
                model_addr  = value[`I2C_ADDR_W-1:0];
                model_start = 1'b1;
            end
            kind_write_byte: begin
                cmd_exp.push_back(pack_cmd(model_start, 1'b1, 1'b0, model_addr));
                data_exp.push_back(value);
                model_start = 1'b0;
            end
            default: begin
                cmd_exp.push_back(pack_cmd(1'b0, 1'b0, 1'b1, model_addr));
                model_start = 1'b0;
            end
        endcase
    endtask

    task automatic build_expected();
        cmd_exp.delete();
        data_exp.delete();
        model_start = 1'b0;
        // single device at 0x50, closed by send stop
        model_req(kind_set_addr, 8'h50);
        foreach (data_blk[i]) begin
            model_req(kind_write_byte, data_blk[i][7:0]);
        end
        model_req(kind_stop, 8'h00);
        // data block once per address, no stop in between
        foreach (addr_blk[a]) begin
            model_req(kind_set_addr, {1'b0, addr_blk[a][6:0]});
            foreach (data_blk[i]) begin
                model_req(kind_write_byte, data_blk[i][7:0]);
            end
        end
        // end of table
        model_req(kind_stop, 8'h00);
    endtask

    // transfers taken where valid and ready meet
    always @(posedge clk) begin
        if (!rst && cmd_valid && cmd_ready) begin
            cmd_act.push_back(pack_cmd(cmd_start, cmd_write, cmd_stop, cmd_address));
        end
        if (!rst && data_tvalid && data_tready) begin
            data_act.push_back(data_tdata);
        end
    end

    // ready driver, random or always high
    initial begin
        cmd_ready   = 1'b0;
        data_tready = 1'b0;
        void'($urandom(32'h7ed5));
        forever begin
            @(posedge clk);
            cmd_ready   <= rand_ready ? 1'($urandom % 2) : 1'b1;
            data_tready <= rand_ready ? 1'($urandom % 2) : 1'b1;
        end
    end

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge clk);
            check_equal("cmd_valid", cmd_valid, 1'b0);
            check_equal("data_tvalid", data_tvalid, 1'b0);
            check_equal("busy", busy, 1'b0);
        end
    endtask

    // one triggered run compared against the model
    task automatic run_sequence(input logic hold_start);
        int n;
        int cyc;
        build_expected();
        cmd_act.delete();
        data_act.delete();
        n   = cmd_exp.size();
        cyc = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        if (!hold_start) begin
            start <= 1'b0;
        end
        // busy rises the cycle after the trigger, stays up until the final stop
        while (cmd_act.size() < n) begin
            @(negedge clk);
            if (cyc > 0 && cmd_act.size() < n - 1) begin
                check_equal("busy", busy, 1'b1);
            end
            cyc++;
        end
        check_equal("busy", busy, 1'b0);
        // nothing more may follow
        repeat (8) @(negedge clk);
        check_equal("cmd word count", cmd_act.size(), n);
        check_equal("data byte count", data_act.size(), data_exp.size());
        check_equal("cmd_valid", cmd_valid, 1'b0);
        foreach (cmd_exp[i]) begin
            check_equal($sformatf("cmd word %0d", i), cmd_act[i], cmd_exp[i]);
        end
        foreach (data_exp[i]) begin
            check_equal($sformatf("data_tdata %0d", i), data_act[i], data_exp[i]);
        end
    endtask

    task automatic test_start_hold();
        run_sequence(1'b1);
        // drop start, raise it again
        @(posedge clk);
        start <= 1'b0;
        run_sequence(1'b0);
    endtask

    initial begin
        start      = 1'b0;
        rand_ready = 1'b0;
        @(negedge rst);
        test_reset_idle();
        run_sequence(1'b0);
        rand_ready = 1'b1;
        run_sequence(1'b0);
        rand_ready = 1'b0;
        test_start_hold();
        $display("Test OK");
        $finish;
    end

    // watchdog
    initial begin
        repeat (num_tests * `INIT_TABLE_LEN * 64) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- verification/i2c_init_chk.sv
// i2c_init_chk concurrent assertions on the cmd and data output channels
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

module i2c_init_chk (
    input logic                   clk,
    input logic                   rst,
    input logic [`I2C_ADDR_W-1:0] cmd_address,
    input logic                   cmd_start,
    input logic                   cmd_write,
    input logic                   cmd_stop,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input logic [`I2C_DATA_W-1:0] data_tdata,
    input logic                   data_tvalid,
    input logic                   data_tready
);

    // cmd word held until ready
    assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid &&
            $stable({cmd_start, cmd_write, cmd_stop, cmd_address}))
        else $error("cmd word dropped or changed before its transfer");

    // data byte held until ready
    assert property (@(posedge clk) disable iff (rst)
        data_tvalid && !data_tready |=> data_tvalid && $stable(data_tdata))
        else $error("data byte dropped or changed before its transfer");

    // write and stop exclusive
    assert property (@(posedge clk) disable iff (rst) !(cmd_write && cmd_stop))
        else $error("cmd_write and cmd_stop high together");

    // a byte only rides with a write
    assert property (@(posedge clk) disable iff (rst) data_tvalid |-> cmd_write)
        else $error("data_tvalid high without a write command");

endmodule

//--- verification/tb_clk_gen.sv
// tb_clk_gen free-running clock and power-on reset
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real period     = 20.0,
    parameter int  rst_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- rtl/i2c_init.sv
// i2c_init top level with rom, sequencer and command output stage
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

module i2c_init (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    output logic                   busy,
    // i2c master command channel
    output logic [`I2C_ADDR_W-1:0] cmd_address,
    output logic                   cmd_start,
    output logic                   cmd_write,
    output logic                   cmd_stop,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    // i2c master data channel
    output logic [`I2C_DATA_W-1:0] data_tdata,
    output logic                   data_tvalid,
    input  logic                   data_tready
);
    import init_table_pkg::*;

    init_ptr_t   rd_addr;
    init_entry_t rd_data;

    // sequencer to output stage requests
    init_cmd_if cmd_if0 ();

    init_rom rom0 (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    init_sequencer seq0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cmd     (cmd_if0.seq)
    );

    i2c_cmd_out cmd_out0 (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd_if0.out),
        .cmd_address (cmd_address),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_stop    (cmd_stop),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .data_tdata  (data_tdata),
        .data_tvalid (data_tvalid),
        .data_tready (data_tready)
    );

endmodule

//--- rtl/i2c_cmd_out.sv
// i2c_cmd_out command and data output registers with valid/ready handling
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

module i2c_cmd_out (
    input  logic                   clk,
    input  logic                   rst,
    init_cmd_if.out                cmd,
    output logic [`I2C_ADDR_W-1:0] cmd_address,
    output logic                   cmd_start,
    output logic                   cmd_write,
    output logic                   cmd_stop,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output logic [`I2C_DATA_W-1:0] data_tdata,
    output logic                   data_tvalid,
    input  logic                   data_tready
);
    import i2c_cmd_pkg::*;

    logic cmd_xfer;
    logic data_xfer;

    assign cmd_xfer  = cmd_valid & cmd_ready;
    assign data_xfer = data_tvalid & data_tready;

    // sequencer waits on this
    assign cmd.pending = cmd_valid | data_tvalid;

    // address and byte only change on a request
    always_ff @(posedge clk) begin
        if (cmd.issue && cmd.kind == kind_set_addr) begin
            cmd_address <= cmd.addr;
        end
        if (cmd.issue && cmd.kind == kind_write_byte) begin
            data_tdata <= cmd.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid   <= 1'b0;
            cmd_start   <= 1'b0;
            cmd_write   <= 1'b0;
            cmd_stop    <= 1'b0;
            data_tvalid <= 1'b0;
        end else begin
            // start goes out with the first cmd word after an address
            if (cmd_xfer) begin
                cmd_valid <= 1'b0;
                cmd_start <= 1'b0;
            end
            if (data_xfer) begin
                data_tvalid <= 1'b0;
            end
            // requests only come while both channels are empty
            if (cmd.issue) begin
                case (cmd.kind)
                    kind_set_addr: begin
                        cmd_start <= 1'b1;
                    end
                    kind_write_byte: begin
                        cmd_valid   <= 1'b1;
                        cmd_write   <= 1'b1;
                        cmd_stop    <= 1'b0;
                        data_tvalid <= 1'b1;
                    end
                    kind_stop: begin
                        // address kept for a later write
                        cmd_valid <= 1'b1;
                        cmd_write <= 1'b0;
                        cmd_stop  <= 1'b1;
                        cmd_start <= 1'b0;
                    end
                    default: begin
                        // unused encoding ignored
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/init_sequencer.sv
// init_sequencer table-walking fsm with data-block and address-block pointers
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

module init_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic                        busy,
    output init_table_pkg::init_ptr_t   rd_addr,
    input  init_table_pkg::init_entry_t rd_data,
    init_cmd_if.seq                     cmd
);
    import init_table_pkg::*;
    import i2c_cmd_pkg::*;

    seq_state_e             state_q;
    seq_state_e             state_d;
    // current rom index
    init_ptr_t              addr_q;
    init_ptr_t              addr_d;
    // first entry after start data block
    init_ptr_t              data_ptr_q;
    init_ptr_t              data_ptr_d;
    // next address entry of the address block
    init_ptr_t              addr_ptr_q;
    init_ptr_t              addr_ptr_d;
    // device address for the replayed data block
    logic [`I2C_ADDR_W-1:0] cur_addr_q;
    logic [`I2C_ADDR_W-1:0] cur_addr_d;
    logic                   start_latched_q;
    logic                   start_latched_d;
    init_op_e               op;
    init_ptr_t              addr_inc;
    logic                   in_block;

    function automatic init_op_e decode(init_entry_t e);
        init_op_e k;
        casez (e)
            9'b1_????_????: k = op_write_data;
            9'b0_1???_????: k = op_write_addr;
            9'b0_0100_0001: k = op_send_stop;
            9'b0_0000_1001: k = op_data_block;
            9'b0_0000_1000: k = op_addr_block;
            9'b0_0000_0011: k = op_write_cur_addr;
            9'b0_0000_0001: k = op_exit_mode;
            9'b0_0000_0000: k = op_end;
            // delay and other codes
            default:        k = op_unknown;
        endcase
        return k;
    endfunction

    assign op       = decode(rd_data);
    assign addr_inc = addr_q + 1'b1;
    // states where writes and stops go out
    assign in_block = (state_q == st_run) || (state_q == st_replay);

    // rom address presented combinationally, data back next edge
    assign rd_addr = addr_d;

    always_comb begin
        state_d         = state_q;
        addr_d          = addr_q;
        data_ptr_d      = data_ptr_q;
        addr_ptr_d      = addr_ptr_q;
        cur_addr_d      = cur_addr_q;
        start_latched_d = start_latched_q;

        cmd.issue = 1'b0;
        cmd.kind  = kind_write_byte;
        cmd.addr  = rd_data[`I2C_ADDR_W-1:0];
        cmd.data  = rd_data[`I2C_DATA_W-1:0];

        // everything holds while a word waits for ready
        if (!cmd.pending) begin
            if (state_q == st_idle) begin
                // rising start only
                if (start && !start_latched_q) begin
                    addr_d          = '0;
                    start_latched_d = 1'b1;
                    state_d         = st_run;
                end
            end else begin
                // most entries just step forward
                addr_d = addr_inc;
                case (op)
                    op_end: begin
                        cmd.issue = 1'b1;
                        cmd.kind  = kind_stop;
                        addr_d    = addr_q;
                        state_d   = st_idle;
                    end
                    op_data_block: begin
                        // a new data block restarts the address search
                        data_ptr_d = addr_inc;
                        state_d    = st_find_addr_block;
                    end
                    op_exit_mode: begin
                        state_d = st_run;
                    end
                    op_addr_block: begin
                        if (state_q == st_find_addr_block) begin
                            addr_ptr_d = addr_inc;
                            state_d    = st_next_addr;
                        end else if (state_q == st_replay) begin
                            // end of data block, fetch the next address
                            addr_d  = addr_ptr_q;
                            state_d = st_next_addr;
                        end
                    end
                    op_write_addr: begin
                        if (state_q == st_next_addr) begin
                            // store it and jump back to the data block
                            cur_addr_d = rd_data[`I2C_ADDR_W-1:0];
                            addr_ptr_d = addr_inc;
                            addr_d     = data_ptr_q;
                            state_d    = st_replay;
                        end else if (in_block) begin
                            cmd.issue = 1'b1;
                            cmd.kind  = kind_set_addr;
                        end
                    end
                    op_write_cur_addr: begin
                        if (state_q == st_replay) begin
                            cmd.issue = 1'b1;
                            cmd.kind  = kind_set_addr;
                            cmd.addr  = cur_addr_q;
                        end
                    end
                    op_write_data: begin
                        cmd.issue = in_block;
                        cmd.kind  = kind_write_byte;
                    end
                    op_send_stop: begin
                        cmd.issue = in_block;
                        cmd.kind  = kind_stop;
                    end
                    default: begin
                        // unknown entry skipped
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q         <= st_idle;
            addr_q          <= '0;
            data_ptr_q      <= '0;
            addr_ptr_q      <= '0;
            cur_addr_q      <= '0;
            start_latched_q <= 1'b0;
            busy            <= 1'b0;
        end else begin
            state_q    <= state_d;
            addr_q     <= addr_d;
            data_ptr_q <= data_ptr_d;
            addr_ptr_q <= addr_ptr_d;
            cur_addr_q <= cur_addr_d;
            // latch clears as soon as start drops
            start_latched_q <= start & start_latched_d;
            // one cycle behind the state
            busy <= (state_q != st_idle);
        end
    end

endmodule

//--- rtl/init_rom.sv
// init_rom table contents with a registered read port
`timescale 1ns/100ps

module init_rom (
    input  logic                        clk,
    input  init_table_pkg::init_ptr_t   rd_addr,
    output init_table_pkg::init_entry_t rd_data
);
    import init_table_pkg::*;

    init_entry_t rom_word;

    always_comb begin
        case (rd_addr)
            // single device at 0x50, register 0x0004 gets 0x11223344
            0:  rom_word = {2'b01, 7'h50};
            1:  rom_word = {1'b1, 8'h00};
            2:  rom_word = {1'b1, 8'h04};
            3:  rom_word = {1'b1, 8'h11};
            4:  rom_word = {1'b1, 8'h22};
            5:  rom_word = {1'b1, 8'h33};
            6:  rom_word = {1'b1, 8'h44};
            // close the single-device transfer
            7:  rom_word = 9'b0_0100_0001;
            // data block, replayed per address below
            8:  rom_word = 9'b0_0000_1001;
            9:  rom_word = 9'b0_0000_0011;
            10: rom_word = {1'b1, 8'h00};
            11: rom_word = {1'b1, 8'h04};
            12: rom_word = {1'b1, 8'h11};
            13: rom_word = {1'b1, 8'h22};
            14: rom_word = {1'b1, 8'h33};
            15: rom_word = {1'b1, 8'h44};
            // address block 0x50 to 0x53
            16: rom_word = 9'b0_0000_1000;
            17: rom_word = {2'b01, 7'h50};
            18: rom_word = {2'b01, 7'h51};
            19: rom_word = {2'b01, 7'h52};
            20: rom_word = {2'b01, 7'h53};
            // leave multi-device mode
            21: rom_word = 9'b0_0000_0001;
            // end of table
            22: rom_word = 9'b0_0000_0000;
            // unused indexes read as end
            default: rom_word = 9'b0_0000_0000;
        endcase
    end

    // registered read
    always_ff @(posedge clk) begin
        rd_data <= rom_word;
    end

endmodule

//--- rtl/init_cmd_if.sv
// init_cmd_if interface between the sequencer and the command output stage
`timescale 1ns/100ps
`include "i2c_init_defines.svh"

interface init_cmd_if;
    import i2c_cmd_pkg::*;

    // one-cycle request strobe, always taken
    logic                   issue;
    cmd_kind_e              kind;
    logic [`I2C_ADDR_W-1:0] addr;
    logic [`I2C_DATA_W-1:0] data;

    // cmd or data word still waiting for ready
    logic                   pending;

    // sequencer side
    modport seq (
        output issue,
        output kind,
        output addr,
        output data,
        input  pending
    );

    // output stage side
    modport out (
        input  issue,
        input  kind,
        input  addr,
        input  data,
        output pending
    );

endinterface

//--- rtl/i2c_cmd_pkg.sv
// request kinds from the sequencer to the i2c command output stage
package i2c_cmd_pkg;

    // kind_set_addr
    //   load the device address, arm the start flag
    //   no word goes out yet
    // kind_write_byte
    //   cmd word with write set plus one data byte
    // kind_stop
    //   cmd word with stop set, start flag dropped
    typedef enum logic [1:0] {
        kind_set_addr,
        kind_write_byte,
        kind_stop
    } cmd_kind_e;

endpackage

//--- rtl/init_table_pkg.sv
// init table entry, rom index, decoded opcode and sequencer state types
`include "i2c_init_defines.svh"

package init_table_pkg;

    // entry encoding
    //   00 0000000  end of table
    //   00 0000001  exit multi-device mode
    //   00 0000011  start write to current address
    //   00 0001000  start address block
    //   00 0001001  start data block
    //   00 1000001  send i2c stop
    //   01 aaaaaaa  start write to address a
    //   1 dddddddd  write data byte d
    // anything else is skipped
    typedef logic [`INIT_ENTRY_W-1:0] init_entry_t;

    typedef logic [`INIT_PTR_W-1:0] init_ptr_t;

    // decoded entry kind
    // nine kinds, so one bit more than three
    typedef enum logic [3:0] {
        op_end,
        op_exit_mode,
        op_write_cur_addr,
        op_addr_block,
        op_data_block,
        op_send_stop,
        op_write_addr,
        op_write_data,
        op_unknown
    } init_op_e;

    // st_find_addr_block: skipping a data block, looking for its addresses
    // st_next_addr: reading the next address of the block
    // st_replay: running the data block for the stored address
    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_find_addr_block,
        st_next_addr,
        st_replay
    } seq_state_e;

endpackage

//--- include/i2c_init_defines.svh
// init table size, entry width and i2c field width macros
`ifndef I2C_INIT_DEFINES_SVH
`define I2C_INIT_DEFINES_SVH

// number of entries in the init rom
`define INIT_TABLE_LEN 23

// one table word
// opcode bits plus payload
`define INIT_ENTRY_W 9

// rom index width
`define INIT_PTR_W ($clog2(`INIT_TABLE_LEN))

// 7-bit i2c device address
`define I2C_ADDR_W 7

// one i2c data byte
`define I2C_DATA_W 8

`endif
